// File: load_store_path.f
design/lsu_pkg.sv
design/addr_gen_stage.sv
design/mem_access_stage.sv
design/load_align_stage.sv
design/load_store_path.sv
test/axi_mem_model.sv
test/load_store_path_properties.sv
test/load_store_path_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module load_store_path_tb -f load_store_path.f -o sim_load_store_path

output=$(./obj_dir/sim_load_store_path +verilator+error+limit+100 2>&1 || true)
echo "$output"

if grep -q "SIMULATION PASSED" <<< "$output"; then
    exit 0
fi
exit 1

// File: test/load_store_path_tb.sv
module load_store_path_tb;
    import lsu_pkg::*;

    localparam logic [31:0] SEED          = 32'hc09be073;
    localparam logic [31:0] ERR_BASE      = 32'hE000_0000;
    localparam logic [31:0] ERR_END       = 32'hE000_FFFF;
    localparam logic [31:0] SDRAM_ADDR    = 32'hA000_0100;
    localparam logic [31:0] PLAIN_ADDR    = 32'h0000_0200;
    localparam int          CYCLES_PER_OP = 200;
    localparam int          RANDOM_OPS    = 60;

    logic            clk;
    logic            rst;
    logic            in_valid;
    logic            in_ready;
    logic [OP_W-1:0] in_op;
    logic [31:0]     in_base;
    logic [31:0]     in_offset;
    logic [31:0]     in_store_data;
    logic            out_valid;
    logic            out_ready;
    logic [31:0]     out_data;
    logic            out_fault;
    logic            awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic            arvalid, arready, rvalid, rready, rlast;
    logic [31:0]     awaddr, wdata, araddr, rdata;
    logic [3:0]      awid, wstrb, bid, arid, rid;
    logic [7:0]      awlen, arlen;
    logic [2:0]      awsize, arsize;
    logic [1:0]      awburst, bresp, arburst, rresp;

    logic [7:0]  shadow [logic [31:0]];
    logic [31:0] exp_data [$];
    logic        exp_fault [$];
    int          issued = 0;
    int          cycles = 0;
    logic        stall_en = 1'b0;

    load_store_path uut (.*);

    axi_mem_model #(.ERR_BASE(ERR_BASE), .ERR_END(ERR_END)) mem_model (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    function automatic logic [OP_W-1:0] mem_op(input logic store, input logic [1:0] size,
                                               input logic uns);
        logic [OP_W-1:0] op;
        op                = '0;
        op[OP_LOAD]       = !store;
        op[OP_STORE]      = store;
        op[OP_SIZE +: 2]  = size;
        op[OP_UNSIGNED]   = uns;
        return op;
    endfunction

    // little endian, so byte i of the data goes to address addr + i.
    task automatic predict(input logic [OP_W-1:0] op, input logic [31:0] addr,
                           input logic [31:0] data);
        int          nbytes;
        logic        is_mem;
        logic        fault;
        logic [31:0] value;
        nbytes = 1 << op[OP_SIZE +: 2];
        is_mem = op[OP_LOAD] || op[OP_STORE];
        fault  = is_mem && (addr % nbytes != 0);
        value  = is_mem ? 32'h0 : addr;
        if (is_mem && !fault && addr >= ERR_BASE && addr <= ERR_END) begin
            fault = 1'b1;
        end else if (is_mem && !fault) begin
            for (int i = 0; i < nbytes; i++) begin
                if (op[OP_STORE]) shadow[addr + i] = data[8*i +: 8];
                else value[8*i +: 8] = shadow[addr + i];
            end
            if (op[OP_LOAD] && !op[OP_UNSIGNED] && value[8*nbytes-1]) begin
                value = value | (32'hFFFF_FFFF << (8 * nbytes));
            end
        end
        exp_data.push_back(value);
        exp_fault.push_back(fault);
    endtask

    task automatic issue(input logic [OP_W-1:0] op, input logic [31:0] base,
                         input logic [31:0] offset, input logic [31:0] data);
        predict(op, base + offset, data);
        in_valid      = 1'b1;
        in_op         = op;
        in_base       = base;
        in_offset     = offset;
        in_store_data = data;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        issued   = issued + 1;
    endtask

    task automatic word_tests(input logic [31:0] base);
        issue(mem_op(1'b1, SIZE_WORD, 1'b0), base, 32'd0, 32'h8765_F0C3);
        issue(mem_op(1'b1, SIZE_BYTE, 1'b0), base, 32'd1, 32'hFFFF_FF9A);
        issue(mem_op(1'b1, SIZE_HALF, 1'b0), base, 32'd2, 32'h0000_8001);
        issue(mem_op(1'b0, SIZE_WORD, 1'b0), base, 32'd0, 32'h0);
        issue(mem_op(1'b0, SIZE_BYTE, 1'b0), base, 32'd1, 32'h0);
        issue(mem_op(1'b0, SIZE_BYTE, 1'b1), base, 32'd1, 32'h0);
        issue(mem_op(1'b0, SIZE_BYTE, 1'b0), base, 32'd0, 32'h0);
        issue(mem_op(1'b0, SIZE_HALF, 1'b0), base, 32'd2, 32'h0);
        issue(mem_op(1'b0, SIZE_HALF, 1'b1), base, 32'd2, 32'h0);
        issue(mem_op(1'b0, SIZE_BYTE, 1'b1), base, 32'd3, 32'h0);
    endtask

    task automatic random_tests();
        logic [1:0]  size;
        logic        store;
        logic [31:0] offset;
        stall_en = 1'b1;
        for (int i = 0; i < 4; i++) begin
            issue(mem_op(1'b1, SIZE_WORD, 1'b0), SDRAM_ADDR + 32'h40, 4 * i, $urandom);
        end
        for (int i = 0; i < RANDOM_OPS; i++) begin
            size   = 2'($urandom % 3);
            store  = 1'($urandom % 2);
            offset = $urandom % 16;  // some of these land misaligned.
            issue(mem_op(store, size, 1'($urandom % 2)), SDRAM_ADDR + 32'h40, offset, $urandom);
        end
        stall_en = 1'b0;
    endtask

    always @(posedge clk) begin
        #1;
        out_ready = stall_en ? (($urandom % 4) != 0) : 1'b1;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLES_PER_OP * (issued + 1)) begin
            $display("timeout after %0d cycles with %0d operations issued", cycles, issued);
            abort_run();
        end
    end

    // a result seen here is taken at the next rising edge.
    always @(negedge clk) begin
        if (!rst && out_valid && out_ready) begin
            assert (exp_data.size() != 0) else begin
                $display("a result came out with no operation outstanding");
                abort_run();
            end
            assert (out_data == exp_data[0]) else begin
                $display("FAIL out_data got %h expected %h", out_data, exp_data[0]);
                abort_run();
            end
            assert (out_fault == exp_fault[0]) else begin
                $display("FAIL out_fault got %h expected %h", out_fault, exp_fault[0]);
                abort_run();
            end
            void'(exp_data.pop_front());
            void'(exp_fault.pop_front());
        end
        assert (uut.u_props.violations == 0) else begin
            $display("a bus or handshake property was violated");
            abort_run();
        end
    end

    initial begin
        void'($urandom(SEED));
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_op         = '0;
        in_base       = 32'h0;
        in_offset     = 32'h0;
        in_store_data = 32'h0;
        out_ready     = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        word_tests(SDRAM_ADDR);
        word_tests(PLAIN_ADDR);
        issue(mem_op(1'b0, SIZE_HALF, 1'b0), SDRAM_ADDR, 32'd1, 32'h0);
        issue(mem_op(1'b1, SIZE_WORD, 1'b0), PLAIN_ADDR, 32'd2, 32'h1234_5678);
        issue(mem_op(1'b0, SIZE_WORD, 1'b1), SDRAM_ADDR, 32'd3, 32'h0);
        issue(mem_op(1'b1, SIZE_WORD, 1'b0), ERR_BASE, 32'h10, 32'hDEAD_BEEF);
        issue(mem_op(1'b0, SIZE_WORD, 1'b0), ERR_BASE, 32'h10, 32'h0);
        issue('0, 32'h1234_0000, 32'h0000_5678, 32'h0);  // pass-through returns the sum.
        random_tests();
        while (exp_data.size() != 0) @(posedge clk);
        @(posedge clk);
        if (uut.u_props.violations == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("a bus or handshake property was violated");
            abort_run();
        end
    end

endmodule

// File: test/load_store_path_properties.sv
module load_store_path_properties (
    input logic                     clk,
    input logic                     rst,
    input logic                     in_ready,
    input logic                     out_valid,
    input logic                     out_ready,
    input logic [31:0]              out_data,
    input logic                     out_fault,
    input logic                     ag_valid,
    input logic                     ag_ready,
    input logic [lsu_pkg::OP_W-1:0] ag_op,
    input logic [31:0]              ag_data,
    input logic                     ag_misaligned,
    input logic                     awvalid,
    input logic                     awready,
    input logic [31:0]              awaddr,
    input logic [3:0]               awid,
    input logic [7:0]               awlen,
    input logic [2:0]               awsize,
    input logic [1:0]               awburst,
    input logic                     wvalid,
    input logic                     wready,
    input logic [31:0]              wdata,
    input logic [3:0]               wstrb,
    input logic                     wlast,
    input logic                     bready,
    input logic                     arvalid,
    input logic                     arready,
    input logic [31:0]              araddr,
    input logic [3:0]               arid,
    input logic [7:0]               arlen,
    input logic [2:0]               arsize,
    input logic [1:0]               arburst,
    input logic                     rready
);
    import lsu_pkg::*;

    int unsigned violations = 0;
    logic [1:0]  size_q;
    logic [31:0] data_q;
    logic [3:0]  exp_strb;
    logic [31:0] exp_wdata;

    always_ff @(posedge clk) begin
        if (ag_valid && ag_ready) begin
            size_q <= ag_op[OP_SIZE +: 2];  // the operation now held by the bus master.
            data_q <= ag_data;
        end
    end

    always_comb begin
        if (size_q == SIZE_BYTE) begin
            exp_strb  = 4'b0001 << awaddr[1:0];
            exp_wdata = {24'h0, data_q[7:0]} << {awaddr[1:0], 3'b000};
        end else if (size_q == SIZE_HALF) begin
            exp_strb  = 4'b0011 << {awaddr[1], 1'b0};
            exp_wdata = {16'h0, data_q[15:0]} << {awaddr[1], 4'b0000};
        end else begin
            exp_strb  = 4'b1111;
            exp_wdata = data_q;
        end
    end

    function automatic logic [1:0] burst_for(input logic [31:0] addr);
        logic [31:0] rel;
        rel = addr - SDRAM_BASE;  // offset into the window, wraps for addresses below it.
        return (rel <= SDRAM_END - SDRAM_BASE) ? AXI_BURST_INCR : AXI_BURST_FIXED;
    endfunction

    a_reset_idle: assert property (@(posedge clk) $fell(rst) |->
        (!awvalid && !wvalid && !arvalid && !bready && !rready && !out_valid && in_ready))
        else begin $error("valid outputs not idle after reset."); violations++; end

    a_store_lanes: assert property (@(posedge clk) disable iff (rst)
        wvalid |-> (wstrb == exp_strb && wdata == exp_wdata))
        else begin $error("store lanes do not match size and offset."); violations++; end

    // one beat of four bytes with id 0.
    a_aw_single: assert property (@(posedge clk) disable iff (rst)
        awvalid |-> (awid == 4'h0 && awlen == 8'h00 && awsize == 3'd2))
        else begin $error("write address is not a single word beat."); violations++; end

    a_w_last: assert property (@(posedge clk) disable iff (rst)
        wvalid |-> wlast)
        else begin $error("write beat is not marked last."); violations++; end

    a_ar_single: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> (arid == 4'h0 && arlen == 8'h00 && arsize == 3'd2))
        else begin $error("read address is not a single word beat."); violations++; end

    a_aw_burst: assert property (@(posedge clk) disable iff (rst)
        awvalid |-> (awburst == burst_for(awaddr)))
        else begin $error("awburst does not match the address window."); violations++; end

    a_ar_burst: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> (arburst == burst_for(araddr)))
        else begin $error("arburst does not match the address window."); violations++; end

    a_misaligned_quiet: assert property (@(posedge clk) disable iff (rst)
        (ag_valid && ag_ready && ag_misaligned) |=> (!awvalid && !wvalid && !arvalid))
        else begin $error("misaligned access reached the bus."); violations++; end

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_fault)))
        else begin $error("result changed before it was taken."); violations++; end

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        (arvalid && !arready) |=> (arvalid && $stable(araddr)))
        else begin $error("read address dropped before arready."); violations++; end

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        (awvalid && !awready) |=> (awvalid && $stable(awaddr)))
        else begin $error("write address dropped before awready."); violations++; end

    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        (wvalid && !wready) |=> (wvalid && $stable(wdata) && $stable(wstrb)))
        else begin $error("write data dropped before wready."); violations++; end

endmodule

bind load_store_path load_store_path_properties u_props (.*);

// File: test/axi_mem_model.sv
module axi_mem_model #(
    parameter logic [31:0] ERR_BASE = 32'hE000_0000,
    parameter logic [31:0] ERR_END  = 32'hE000_FFFF
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] awaddr,
    input  logic        wvalid,
    output logic        wready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    output logic        bvalid,
    input  logic        bready,
    output logic [1:0]  bresp,
    output logic [3:0]  bid,
    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rlast,
    output logic [3:0]  rid
);
    import lsu_pkg::*;

    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic [31:0] mem [logic [29:0]];
    logic        aw_seen;
    logic        w_seen;
    logic [31:0] aw_addr_q;
    logic [31:0] w_data_q;
    logic [3:0]  w_strb_q;

    assign bid   = AXI_ID;
    assign rid   = AXI_ID;
    assign rlast = 1'b1;

    function automatic logic in_err(input logic [31:0] addr);
        return (addr >= ERR_BASE) && (addr <= ERR_END);
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem.exists(addr[31:2])) begin
            return mem[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ 32'h5A5A_C3C3;  // words never written read as a pattern.
    endfunction

    function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                          input logic [3:0] strb);
        logic [31:0] word;
        word = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                word[8*i +: 8] = data[8*i +: 8];
            end
        end
        return word;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            aw_seen <= 1'b0;
            w_seen  <= 1'b0;
            bresp   <= RESP_OKAY;
            rresp   <= RESP_OKAY;
            rdata   <= 32'h0;
        end else begin
            awready <= ($urandom % 3) != 0;  // readies come and go at random.
            wready  <= ($urandom % 3) != 0;
            arready <= ($urandom % 3) != 0;
            if (awvalid && awready) begin
                aw_seen   <= 1'b1;
                aw_addr_q <= awaddr;
            end
            if (wvalid && wready) begin
                w_seen   <= 1'b1;
                w_data_q <= wdata;
                w_strb_q <= wstrb;
            end
            if (aw_seen && w_seen && !bvalid) begin
                bvalid  <= 1'b1;
                bresp   <= in_err(aw_addr_q) ? RESP_SLVERR : RESP_OKAY;
                aw_seen <= 1'b0;
                w_seen  <= 1'b0;
                if (!in_err(aw_addr_q)) begin
                    mem[aw_addr_q[31:2]] = merge(read_word(aw_addr_q), w_data_q, w_strb_q);
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                rvalid <= 1'b1;
                rresp  <= in_err(araddr) ? RESP_SLVERR : RESP_OKAY;
                rdata  <= in_err(araddr) ? 32'h0 : read_word(araddr);
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

// File: design/load_store_path.sv
module load_store_path (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [lsu_pkg::OP_W-1:0] in_op,
    input  logic [31:0]             in_base,
    input  logic [31:0]             in_offset,
    input  logic [31:0]             in_store_data,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [31:0]             out_data,
    output logic                    out_fault,

    output logic                    awvalid,
    input  logic                    awready,
    output logic [31:0]             awaddr,
    output logic [3:0]              awid,
    output logic [7:0]              awlen,
    output logic [2:0]              awsize,
    output logic [1:0]              awburst,
    output logic                    wvalid,
    input  logic                    wready,
    output logic [31:0]             wdata,
    output logic [3:0]              wstrb,
    output logic                    wlast,
    input  logic                    bvalid,
    output logic                    bready,
    input  logic [1:0]              bresp,
    input  logic [3:0]              bid,
    output logic                    arvalid,
    input  logic                    arready,
    output logic [31:0]             araddr,
    output logic [3:0]              arid,
    output logic [7:0]              arlen,
    output logic [2:0]              arsize,
    output logic [1:0]              arburst,
    input  logic                    rvalid,
    output logic                    rready,
    input  logic [31:0]             rdata,
    input  logic [1:0]              rresp,
    input  logic                    rlast,
    input  logic [3:0]              rid
);
    import lsu_pkg::*;

    logic            ag_valid;
    logic            ag_ready;
    logic [OP_W-1:0] ag_op;
    logic [31:0]     ag_addr;
    logic [31:0]     ag_data;
    logic            ag_misaligned;
    logic            ma_valid;
    logic            ma_ready;
    logic [OP_W-1:0] ma_op;
    logic [1:0]      ma_addr_lo;
    logic [31:0]     ma_data;
    logic            ma_fault;

    addr_gen_stage u_addr_gen (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_op         (in_op),
        .in_base       (in_base),
        .in_offset     (in_offset),
        .in_store_data (in_store_data),
        .ag_valid      (ag_valid),
        .ag_ready      (ag_ready),
        .ag_op         (ag_op),
        .ag_addr       (ag_addr),
        .ag_data       (ag_data),
        .ag_misaligned (ag_misaligned)
    );

    mem_access_stage u_mem_access (
        .clk           (clk),
        .rst           (rst),
        .ag_valid      (ag_valid),
        .ag_ready      (ag_ready),
        .ag_op         (ag_op),
        .ag_addr       (ag_addr),
        .ag_data       (ag_data),
        .ag_misaligned (ag_misaligned),
        .ma_valid      (ma_valid),
        .ma_ready      (ma_ready),
        .ma_op         (ma_op),
        .ma_addr_lo    (ma_addr_lo),
        .ma_data       (ma_data),
        .ma_fault      (ma_fault),
        .awvalid       (awvalid),
        .awready       (awready),
        .awaddr        (awaddr),
        .awid          (awid),
        .awlen         (awlen),
        .awsize        (awsize),
        .awburst       (awburst),
        .wvalid        (wvalid),
        .wready        (wready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .wlast         (wlast),
        .bvalid        (bvalid),
        .bready        (bready),
        .bresp         (bresp),
        .bid           (bid),
        .arvalid       (arvalid),
        .arready       (arready),
        .araddr        (araddr),
        .arid          (arid),
        .arlen         (arlen),
        .arsize        (arsize),
        .arburst       (arburst),
        .rvalid        (rvalid),
        .rready        (rready),
        .rdata         (rdata),
        .rresp         (rresp),
        .rlast         (rlast),
        .rid           (rid)
    );

    load_align_stage u_load_align (
        .clk        (clk),
        .rst        (rst),
        .ma_valid   (ma_valid),
        .ma_ready   (ma_ready),
        .ma_op      (ma_op),
        .ma_addr_lo (ma_addr_lo),
        .ma_data    (ma_data),
        .ma_fault   (ma_fault),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .out_fault  (out_fault)
    );

endmodule

// File: design/load_align_stage.sv
module load_align_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ma_valid,
    output logic                    ma_ready,
    input  logic [lsu_pkg::OP_W-1:0] ma_op,
    input  logic [1:0]              ma_addr_lo,
    input  logic [31:0]             ma_data,
    input  logic                    ma_fault,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [31:0]             out_data,
    output logic                    out_fault
);
    import lsu_pkg::*;

    logic        take;
    data_word_u  word;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic        uns;
    logic [31:0] result;

    assign ma_ready = !out_valid || out_ready;
    assign take     = ma_valid && ma_ready;
    assign word     = ma_data;
    assign byte_sel = word.b[ma_addr_lo];
    assign half_sel = word.h[ma_addr_lo[1]];
    assign uns      = ma_op[OP_UNSIGNED];

    always_comb begin
        result = ma_data;  // pass-through keeps its address.
        if (ma_op[OP_LOAD]) begin
            case (ma_op[OP_SIZE +: 2])
                SIZE_BYTE: result = {{24{byte_sel[7] & ~uns}}, byte_sel};
                SIZE_HALF: result = {{16{half_sel[15] & ~uns}}, half_sel};
                default:   result = ma_data;
            endcase
        end else if (ma_op[OP_STORE]) begin
            result = 32'h0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_data  <= result;
            out_fault <= ma_fault;
        end
    end

endmodule

// File: design/mem_access_stage.sv
module mem_access_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ag_valid,
    output logic                    ag_ready,
    input  logic [lsu_pkg::OP_W-1:0] ag_op,
    input  logic [31:0]             ag_addr,
    input  logic [31:0]             ag_data,
    input  logic                    ag_misaligned,
    output logic                    ma_valid,
    input  logic                    ma_ready,
    output logic [lsu_pkg::OP_W-1:0] ma_op,
    output logic [1:0]              ma_addr_lo,
    output logic [31:0]             ma_data,
    output logic                    ma_fault,

    output logic                    awvalid,
    input  logic                    awready,
    output logic [31:0]             awaddr,
    output logic [3:0]              awid,
    output logic [7:0]              awlen,
    output logic [2:0]              awsize,
    output logic [1:0]              awburst,
    output logic                    wvalid,
    input  logic                    wready,
    output logic [31:0]             wdata,
    output logic [3:0]              wstrb,
    output logic                    wlast,
    input  logic                    bvalid,
    output logic                    bready,
    input  logic [1:0]              bresp,
    input  logic [3:0]              bid,
    output logic                    arvalid,
    input  logic                    arready,
    output logic [31:0]             araddr,
    output logic [3:0]              arid,
    output logic [7:0]              arlen,
    output logic [2:0]              arsize,
    output logic [1:0]              arburst,
    input  logic                    rvalid,
    output logic                    rready,
    input  logic [31:0]             rdata,
    input  logic [1:0]              rresp,
    input  logic                    rlast,
    input  logic [3:0]              rid
);
    import lsu_pkg::*;

    logic [1:0]  state;
    logic        take;
    logic        is_load;
    logic        is_store;
    logic        is_sdram;
    logic [1:0]  op_size;
    logic [31:0] req_addr;
    logic [1:0]  burst;
    logic        read_done;
    logic        write_done;
    data_word_u  store_lanes;
    logic [3:0]  store_strb;

    assign ag_ready   = (state == ST_IDLE);
    assign ma_valid   = (state == ST_DONE);
    assign take       = ag_valid && ag_ready;
    assign is_load    = ag_op[OP_LOAD];
    assign is_store   = ag_op[OP_STORE];
    assign op_size    = ag_op[OP_SIZE +: 2];
    assign is_sdram   = (ag_addr >= SDRAM_BASE) && (ag_addr <= SDRAM_END);
    assign read_done  = rvalid && rready;
    assign write_done = bvalid && bready;

    // single-beat word transfers only.
    assign awaddr  = req_addr;
    assign awid    = AXI_ID;
    assign awlen   = AXI_LEN_SINGLE;
    assign awsize  = AXI_SIZE_WORD;
    assign awburst = burst;
    assign wlast   = 1'b1;
    assign araddr  = req_addr;
    assign arid    = AXI_ID;
    assign arlen   = AXI_LEN_SINGLE;
    assign arsize  = AXI_SIZE_WORD;
    assign arburst = burst;

    always_comb begin
        store_lanes.w = '0;
        store_strb    = 4'b0000;
        case (op_size)
            SIZE_BYTE: begin
                store_lanes.b[ag_addr[1:0]] = ag_data[7:0];
                store_strb = 4'b0001 << ag_addr[1:0];
            end
            SIZE_HALF: begin
                store_lanes.h[ag_addr[1]] = ag_data[15:0];
                store_strb = ag_addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                store_lanes.w = ag_data;
                store_strb    = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ST_IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
            arvalid <= 1'b0;
            rready  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take) begin
                        if (ag_misaligned || !(is_load || is_store)) begin
                            state <= ST_DONE;  // no bus access needed.
                        end else if (is_load) begin
                            arvalid <= 1'b1;
                            state   <= ST_BUSY;
                        end else begin
                            awvalid <= 1'b1;
                            wvalid  <= 1'b1;
                            bready  <= 1'b1;
                            state   <= ST_BUSY;
                        end
                    end
                end
                ST_BUSY: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                    end
                    if (read_done) begin
                        rready <= 1'b0;
                        state  <= ST_DONE;
                    end
                    if (awvalid && awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wvalid && wready) begin
                        wvalid <= 1'b0;
                    end
                    if (write_done) begin
                        bready <= 1'b0;
                        state  <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    if (ma_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // a response with a stray id or a missing last is reported as a fault as well.
    always_ff @(posedge clk) begin
        if (take) begin
            ma_op      <= ag_op;
            ma_addr_lo <= ag_addr[1:0];
            ma_fault   <= ag_misaligned;
            ma_data    <= (is_load || is_store) ? 32'h0 : ag_addr;
            req_addr   <= ag_addr;
            burst      <= is_sdram ? AXI_BURST_INCR : AXI_BURST_FIXED;
            wdata      <= store_lanes.w;
            wstrb      <= store_strb;
        end
        if (read_done) begin
            ma_data  <= rdata;
            ma_fault <= (rresp != RESP_OKAY) || (rid != AXI_ID) || !rlast;
        end
        if (write_done) begin
            ma_fault <= (bresp != RESP_OKAY) || (bid != AXI_ID);
        end
    end

endmodule

// File: design/addr_gen_stage.sv
module addr_gen_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [lsu_pkg::OP_W-1:0] in_op,
    input  logic [31:0]             in_base,
    input  logic [31:0]             in_offset,
    input  logic [31:0]             in_store_data,
    output logic                    ag_valid,
    input  logic                    ag_ready,
    output logic [lsu_pkg::OP_W-1:0] ag_op,
    output logic [31:0]             ag_addr,
    output logic [31:0]             ag_data,
    output logic                    ag_misaligned
);
    import lsu_pkg::*;

    logic        take;
    logic [31:0] sum;
    logic [1:0]  size;
    logic        is_mem;
    logic        misaligned;

    assign in_ready = !ag_valid || ag_ready;  // the register frees up as it is taken.
    assign take     = in_valid && in_ready;
    assign sum      = in_base + in_offset;
    assign size     = in_op[OP_SIZE +: 2];
    assign is_mem   = in_op[OP_LOAD] || in_op[OP_STORE];

    always_comb begin
        misaligned = 1'b0;
        if (is_mem) begin
            if (size == SIZE_HALF) begin
                misaligned = sum[0];
            end else if (size == SIZE_WORD) begin
                misaligned = (sum[1:0] != 2'b00);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ag_valid <= 1'b0;
        end else if (take) begin
            ag_valid <= 1'b1;
        end else if (ag_ready) begin
            ag_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            ag_op         <= in_op;
            ag_addr       <= sum;
            ag_data       <= in_store_data;
            ag_misaligned <= misaligned;
        end
    end

endmodule

// File: design/lsu_pkg.sv
package lsu_pkg;

    // operation code fields.
    localparam int OP_W        = 5;
    localparam int OP_LOAD     = 0;
    localparam int OP_STORE    = 1;
    localparam int OP_SIZE     = 2;  // lsb of the two size bits.
    localparam int OP_UNSIGNED = 4;

    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    // memory access states.
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_BUSY = 2'd1;
    localparam logic [1:0] ST_DONE = 2'd2;

    // addresses in this window use INCR bursts.
    localparam logic [31:0] SDRAM_BASE = 32'hA000_0000;
    localparam logic [31:0] SDRAM_END  = 32'hBFFF_FFFF;

    localparam logic [3:0] AXI_ID          = 4'h0;
    localparam logic [7:0] AXI_LEN_SINGLE  = 8'h00;
    localparam logic [2:0] AXI_SIZE_WORD   = 3'd2;
    localparam logic [1:0] AXI_BURST_INCR  = 2'b01;
    localparam logic [1:0] AXI_BURST_FIXED = 2'b00;
    localparam logic [1:0] RESP_OKAY       = 2'b00;

    typedef union packed {
        logic [3:0][7:0]  b;
        logic [1:0][15:0] h;
        logic [31:0]      w;
    } data_word_u;

endpackage
